//--- verilog.f
src/snake_pkg.sv
src/board_map.sv
src/frame_tracker.sv
src/tile_update_emitter.sv
src/snake_display_top.sv
verif/snake_display_assertions.sv
verif/tb_snake_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_snake_display -Mdir obj_dir -o tb_sim \
    && { ./obj_dir/tb_sim 2>&1 | tee sim.log; } \
    || { echo "build or run failed"; exit 1; }

! grep -q "STATUS: FAIL" sim.log && grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verif/tb_snake_display.sv
`timescale 1ns/1ps

module tb_snake_display;

    // clock period in ns and the number of full sweeps the test runs.
    localparam int CLK_PERIOD_NS  = 4;
    localparam int NUM_SWEEPS     = 6;
    // every sweep may take up to twice its tiles because of scan gaps.
    localparam int TIMEOUT_CYCLES = NUM_SWEEPS * snake_pkg::NUM_TILES * 2 + 1000;

    logic                   clk = 1'b0;
    logic                   nrst;
    logic                   scan_en;
    logic                   wr_en;
    snake_pkg::coord_t      wr_x;
    snake_pkg::coord_t      wr_y;
    snake_pkg::obj_t        wr_code;
    logic                   upd_valid;
    snake_pkg::coord_t      upd_x;
    snake_pkg::coord_t      upd_y;
    snake_pkg::obj_t        upd_code;
    logic                   sweep_done;
    snake_pkg::tile_count_t sweep_changes;

    // the model board holds what the game side has written.
    snake_pkg::obj_t board [snake_pkg::GRID_W][snake_pkg::GRID_H];
    // what the display has been told so far, and its state when the sweep began.
    snake_pkg::obj_t model_frame [snake_pkg::GRID_W][snake_pkg::GRID_H];
    snake_pkg::obj_t start_frame [snake_pkg::GRID_W][snake_pkg::GRID_H];

    string       test_name = "reset";
    logic [31:0] rng_state;
    int          upd_count;
    int          last_changes;

    snake_display_top DUT (
        .clk           (clk),
        .nrst          (nrst),
        .scan_en       (scan_en),
        .wr_en         (wr_en),
        .wr_x          (wr_x),
        .wr_y          (wr_y),
        .wr_code       (wr_code),
        .upd_valid     (upd_valid),
        .upd_x         (upd_x),
        .upd_y         (upd_y),
        .upd_code      (upd_code),
        .sweep_done    (sweep_done),
        .sweep_changes (sweep_changes)
    );

    bind snake_display_top snake_display_assertions u_assertions (
        .clk        (clk),
        .nrst       (nrst),
        .upd_valid  (upd_valid),
        .upd_x      (upd_x),
        .upd_y      (upd_y),
        .upd_code   (upd_code),
        .sweep_done (sweep_done)
    );

    // half a period of 2 ns gives the 4 ns clock.
    always #2 clk = ~clk;

    task automatic stop_on_failure();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_value(input string what, input int exp, input int act);
        $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
        stop_on_failure();
    endtask

    task automatic report_problem(input string what);
        $display("** Error [%s] %s", test_name, what);
        stop_on_failure();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // the code a tile should be drawn with.
    // the outer ring is always border, then head, body and apple in that order.
    function automatic snake_pkg::obj_t expected_code(input int tx, input int ty);
        if ((tx == 0) || (tx == snake_pkg::GRID_W - 1) ||
            (ty == 0) || (ty == snake_pkg::GRID_H - 1)) begin
            return snake_pkg::OBJ_BORDER;
        end
        if (board[tx][ty] == snake_pkg::OBJ_HEAD) begin
            return snake_pkg::OBJ_HEAD;
        end
        if (board[tx][ty] == snake_pkg::OBJ_BODY) begin
            return snake_pkg::OBJ_BODY;
        end
        if (board[tx][ty] == snake_pkg::OBJ_APPLE) begin
            return snake_pkg::OBJ_APPLE;
        end
        return snake_pkg::OBJ_EMPTY;
    endfunction

    // every redraw must carry the expected code and must really change the tile.
    task automatic check_update();
        snake_pkg::obj_t exp;
        exp = expected_code(int'(upd_x), int'(upd_y));
        assert (upd_code == exp) else
            report_value($sformatf("code of tile (%0d,%0d)", upd_x, upd_y),
                         int'(exp), int'(upd_code));
        assert (model_frame[upd_x][upd_y] != exp) else
            report_problem($sformatf("tile (%0d,%0d) was redrawn without a change",
                                     upd_x, upd_y));
        model_frame[upd_x][upd_y] = upd_code;
        upd_count++;
    endtask

    // at the end of a sweep every tile must be up to date.
    // the count is the number of tiles that differ from the frame at sweep start.
    task automatic check_sweep();
        int exp_cnt;
        snake_pkg::obj_t code;
        exp_cnt = 0;
        for (int tx = 0; tx < snake_pkg::GRID_W; tx++) begin
            for (int ty = 0; ty < snake_pkg::GRID_H; ty++) begin
                code = expected_code(tx, ty);
                if (code != start_frame[tx][ty]) begin
                    exp_cnt++;
                end
                assert (model_frame[tx][ty] == code) else
                    report_problem($sformatf("tile (%0d,%0d) was not redrawn in the sweep",
                                             tx, ty));
            end
        end
        assert (int'(sweep_changes) == exp_cnt) else
            report_value("sweep_changes against model", exp_cnt, int'(sweep_changes));
        assert (int'(sweep_changes) == upd_count) else
            report_value("sweep_changes against strobes seen", upd_count,
                         int'(sweep_changes));
        last_changes = int'(sweep_changes);
        start_frame  = model_frame;
        upd_count    = 0;
    endtask

    // outputs are sampled on the falling edge, half a period after they settle.
    // the sweep end is handled first, since an update in the same cycle
    // already belongs to the next sweep.
    always @(negedge clk) begin
        if (nrst) begin
            if (sweep_done) begin
                check_sweep();
            end
            if (upd_valid) begin
                check_update();
            end
        end
    end

    // all stimulus tasks start and end 1 ns after a rising edge.
    task automatic write_tile(input int tx, input int ty, input snake_pkg::obj_t code);
        wr_en   = 1'b1;
        wr_x    = snake_pkg::coord_t'(tx);
        wr_y    = snake_pkg::coord_t'(ty);
        wr_code = code;
        if ((code == snake_pkg::OBJ_HEAD) || (code == snake_pkg::OBJ_BODY) ||
            (code == snake_pkg::OBJ_APPLE)) begin
            board[tx][ty] = code;
        end else begin
            board[tx][ty] = snake_pkg::OBJ_EMPTY;
        end
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic random_writes(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = next_random();
            write_tile(int'(r[3:0]), int'(r[7:4]) % snake_pkg::GRID_H,
                       snake_pkg::obj_t'(r[10:8]));
        end
    endtask

    // the scan sits at (0,0) on entry and returns there after 192 enabled edges.
    // the board is only written between sweeps, with the scan held on a border tile.
    task automatic run_sweep(input bit with_gaps);
        int enabled;
        logic [31:0] r;
        enabled = 0;
        while (enabled < snake_pkg::NUM_TILES) begin
            r = next_random();
            if (with_gaps && (r[1:0] == 2'b00)) begin
                scan_en = 1'b0;
            end else begin
                scan_en = 1'b1;
                enabled++;
            end
            @(posedge clk);
            #1;
        end
        scan_en = 1'b0;
        do begin
            @(negedge clk);
        end while (!sweep_done);
        @(posedge clk);
        #1;
    endtask

    task automatic expect_changes(input int exp);
        assert (last_changes == exp) else
            report_value("changes in sweep", exp, last_changes);
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
        report_problem("watchdog expired before all sweeps finished");
    end

    initial begin
        nrst      = 1'b0;
        scan_en   = 1'b0;
        wr_en     = 1'b0;
        wr_x      = '0;
        wr_y      = '0;
        wr_code   = snake_pkg::OBJ_EMPTY;
        rng_state = 32'ha4ab;
        upd_count = 0;
        last_changes = -1;
        for (int tx = 0; tx < snake_pkg::GRID_W; tx++) begin
            for (int ty = 0; ty < snake_pkg::GRID_H; ty++) begin
                board[tx][ty]       = snake_pkg::OBJ_EMPTY;
                model_frame[tx][ty] = snake_pkg::OBJ_EMPTY;
                start_frame[tx][ty] = snake_pkg::OBJ_EMPTY;
            end
        end
        repeat (5) @(posedge clk);
        #1;
        nrst = 1'b1;

        // an empty board only shows the 52 ring tiles.
        test_name = "first_sweep";
        run_sweep(1'b0);
        expect_changes(52);

        test_name = "idle_sweep";
        run_sweep(1'b0);
        expect_changes(0);

        // a short snake heading right, plus one apple.
        test_name = "place_objects";
        write_tile(5, 5, snake_pkg::OBJ_HEAD);
        write_tile(4, 5, snake_pkg::OBJ_BODY);
        write_tile(3, 5, snake_pkg::OBJ_BODY);
        write_tile(3, 6, snake_pkg::OBJ_BODY);
        write_tile(10, 8, snake_pkg::OBJ_APPLE);
        run_sweep(1'b0);
        expect_changes(5);

        // ring writes and an unknown code on an empty tile must stay invisible.
        test_name = "clear_and_replace";
        write_tile(3, 6, snake_pkg::OBJ_EMPTY);
        write_tile(4, 5, snake_pkg::OBJ_HEAD);
        write_tile(0, 3, snake_pkg::OBJ_BODY);
        write_tile(15, 7, snake_pkg::OBJ_APPLE);
        write_tile(7, 2, 3'd7);
        run_sweep(1'b0);
        expect_changes(2);

        test_name = "random_gaps_a";
        random_writes(16);
        run_sweep(1'b1);

        test_name = "random_gaps_b";
        random_writes(16);
        run_sweep(1'b1);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- verif/snake_display_assertions.sv
`timescale 1ns/1ps

module snake_display_assertions (
    input logic              clk,
    input logic              nrst,
    input logic              upd_valid,
    input snake_pkg::coord_t upd_x,
    input snake_pkg::coord_t upd_y,
    input snake_pkg::obj_t   upd_code,
    input logic              sweep_done
);

    // the redraw targets a tile on the outer ring of the grid.
    logic upd_on_ring;

    assign upd_on_ring = (upd_x == '0) || (upd_x == snake_pkg::X_MAX) ||
                         (upd_y == '0) || (upd_y == snake_pkg::Y_MAX);

    // no strobe may leave the display side while it is held in reset.
    quiet_in_reset: assert property (@(posedge clk)
        !nrst |-> (!upd_valid && !sweep_done))
        else $error("redraw or sweep strobe raised during reset");

    // border is the highest code the display can be asked to draw.
    code_in_range: assert property (@(posedge clk) disable iff (!nrst)
        upd_valid |-> (upd_code <= snake_pkg::OBJ_BORDER))
        else $error("redraw carries an unknown object code");

    // the ring is drawn as border whatever the game side wrote there.
    ring_is_border: assert property (@(posedge clk) disable iff (!nrst)
        (upd_valid && upd_on_ring) |-> (upd_code == snake_pkg::OBJ_BORDER))
        else $error("ring tile redrawn with a code other than border");

    // a sweep lasts 192 enabled cycles, so two ends cannot be adjacent.
    single_done_pulse: assert property (@(posedge clk) disable iff (!nrst)
        sweep_done |=> !sweep_done)
        else $error("sweep end reported in two consecutive cycles");

endmodule

//--- src/snake_display_top.sv
`timescale 1ns/1ps

module snake_display_top (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   scan_en,
    input  logic                   wr_en,
    input  snake_pkg::coord_t      wr_x,
    input  snake_pkg::coord_t      wr_y,
    input  snake_pkg::obj_t        wr_code,
    output logic                   upd_valid,
    output snake_pkg::coord_t      upd_x,
    output snake_pkg::coord_t      upd_y,
    output snake_pkg::obj_t        upd_code,
    output logic                   sweep_done,
    output snake_pkg::tile_count_t sweep_changes
);

    // board flags for the tile under the scanner.
    logic              border;
    logic              head;
    logic              body;
    logic              apple;

    // scanner position, resolved code and change flag.
    snake_pkg::coord_t scan_x;
    snake_pkg::coord_t scan_y;
    snake_pkg::obj_t   scan_code;
    logic              scan_diff;

    // the game side writes here, the scanner reads from here.
    board_map u_board_map (
        .clk     (clk),
        .nrst    (nrst),
        .wr_en   (wr_en),
        .wr_x    (wr_x),
        .wr_y    (wr_y),
        .wr_code (wr_code),
        .rd_x    (scan_x),
        .rd_y    (scan_y),
        .border  (border),
        .head    (head),
        .body    (body),
        .apple   (apple)
    );

    frame_tracker u_frame_tracker (
        .clk      (clk),
        .nrst     (nrst),
        .enable   (scan_en),
        .border   (border),
        .head     (head),
        .body     (body),
        .apple    (apple),
        .obj_code (scan_code),
        .x        (scan_x),
        .y        (scan_y),
        .diff     (scan_diff)
    );

    // turns change flags into redraw commands and sweep statistics.
    tile_update_emitter u_tile_update_emitter (
        .clk           (clk),
        .nrst          (nrst),
        .scan_en       (scan_en),
        .x             (scan_x),
        .y             (scan_y),
        .obj_code      (scan_code),
        .diff          (scan_diff),
        .upd_valid     (upd_valid),
        .upd_x         (upd_x),
        .upd_y         (upd_y),
        .upd_code      (upd_code),
        .sweep_done    (sweep_done),
        .sweep_changes (sweep_changes)
    );

endmodule

//--- src/tile_update_emitter.sv
`timescale 1ns/1ps

module tile_update_emitter (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   scan_en,
    input  snake_pkg::coord_t      x,
    input  snake_pkg::coord_t      y,
    input  snake_pkg::obj_t        obj_code,
    input  logic                   diff,
    output logic                   upd_valid,
    output snake_pkg::coord_t      upd_x,
    output snake_pkg::coord_t      upd_y,
    output snake_pkg::obj_t        upd_code,
    output logic                   sweep_done,
    output snake_pkg::tile_count_t sweep_changes
);

    // tile data from the previous cycle, which is what diff refers to.
    snake_pkg::coord_t      x_q;
    snake_pkg::coord_t      y_q;
    snake_pkg::obj_t        code_q;
    // the previous cycle evaluated the last tile with the scan enabled.
    logic                   last_q;
    // running number of redraws within the current sweep.
    snake_pkg::tile_count_t change_cnt;
    snake_pkg::tile_count_t sweep_total;
    logic                   done_q;
    snake_pkg::tile_count_t changes_q;

    // the data is captured every cycle and only has meaning with diff.
    always_ff @(posedge clk) begin
        x_q    <= x;
        y_q    <= y;
        code_q <= obj_code;
    end

    // total of the sweep that ends now, including its last tile.
    assign sweep_total = change_cnt + snake_pkg::tile_count_t'(diff);

    // when a sweep ends, the counter restarts at zero and the total is
    // published together with the done pulse.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            last_q     <= 1'b0;
            change_cnt <= '0;
            done_q     <= 1'b0;
            changes_q  <= '0;
        end else begin
            last_q <= scan_en && (x == snake_pkg::X_MAX) && (y == snake_pkg::Y_MAX);
            done_q <= last_q;
            if (last_q) begin
                change_cnt <= '0;
                changes_q  <= sweep_total;
            end else begin
                change_cnt <= sweep_total;
            end
        end
    end

    // the redraw command goes out in the same cycle as diff.
    assign upd_valid     = diff;
    assign upd_x         = x_q;
    assign upd_y         = y_q;
    assign upd_code      = code_q;
    assign sweep_done    = done_q;
    assign sweep_changes = changes_q;

endmodule

//--- src/frame_tracker.sv
`timescale 1ns/1ps

module frame_tracker (
    input  logic              clk,
    input  logic              nrst,
    input  logic              enable,
    input  logic              border,
    input  logic              head,
    input  logic              body,
    input  logic              apple,
    output snake_pkg::obj_t   obj_code,
    output snake_pkg::coord_t x,
    output snake_pkg::coord_t y,
    output logic              diff
);

    // the last drawn frame, one code per tile.
    snake_pkg::obj_t frame [snake_pkg::GRID_W][snake_pkg::GRID_H];

    // current scan position and its successor.
    snake_pkg::coord_t cur_x;
    snake_pkg::coord_t cur_y;
    snake_pkg::coord_t next_x;
    snake_pkg::coord_t next_y;

    // the code drawn at the current tile last time it was evaluated.
    snake_pkg::obj_t   drawn_code;
    // change flag for the current tile, registered into diff.
    logic              next_d;
    logic              d;

    // the flags come from the board map for the tile at (cur_x, cur_y).
    // border outranks head, head outranks body, body outranks apple.
    always_comb begin
        if (border) begin
            obj_code = snake_pkg::OBJ_BORDER;
        end else if (head) begin
            obj_code = snake_pkg::OBJ_HEAD;
        end else if (body) begin
            obj_code = snake_pkg::OBJ_BODY;
        end else if (apple) begin
            obj_code = snake_pkg::OBJ_APPLE;
        end else begin
            obj_code = snake_pkg::OBJ_EMPTY;
        end
    end

    assign drawn_code = frame[cur_x][cur_y];

    // a redraw is needed whenever the resolved code differs from the frame.
    assign next_d = (obj_code != drawn_code);

    // raster order, column first, then row.
    // after the bottom right tile the scan wraps to the top left.
    always_comb begin
        next_x = cur_x;
        next_y = cur_y;
        if (enable) begin
            if (cur_x == snake_pkg::X_MAX) begin
                next_x = '0;
                if (cur_y == snake_pkg::Y_MAX) begin
                    next_y = '0;
                end else begin
                    next_y = cur_y + 4'd1;
                end
            end else begin
                next_x = cur_x + 4'd1;
            end
        end
    end

    // the frame is rewritten every cycle, not only when enabled.
    // a held scan therefore keeps tracking its tile, and a change seen
    // while held is reported once and not again when the scan moves on.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < snake_pkg::GRID_W; i++) begin
                for (int j = 0; j < snake_pkg::GRID_H; j++) begin
                    frame[i][j] <= snake_pkg::OBJ_EMPTY;
                end
            end
        end else begin
            frame[cur_x][cur_y] <= obj_code;
        end
    end

    // position and change flag.
    // diff in a cycle belongs to the tile evaluated at the edge before it.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cur_x <= '0;
            cur_y <= '0;
            d     <= 1'b0;
        end else begin
            cur_x <= next_x;
            cur_y <= next_y;
            d     <= next_d;
        end
    end

    assign x    = cur_x;
    assign y    = cur_y;
    assign diff = d;

endmodule

//--- src/board_map.sv
`timescale 1ns/1ps

module board_map (
    input  logic              clk,
    input  logic              nrst,
    input  logic              wr_en,
    input  snake_pkg::coord_t wr_x,
    input  snake_pkg::coord_t wr_y,
    input  snake_pkg::obj_t   wr_code,
    input  snake_pkg::coord_t rd_x,
    input  snake_pkg::coord_t rd_y,
    output logic              border,
    output logic              head,
    output logic              body,
    output logic              apple
);

    // one stored object code per tile, indexed by column then row.
    snake_pkg::obj_t tiles [snake_pkg::GRID_W][snake_pkg::GRID_H];

    // the code that is actually written after filtering.
    snake_pkg::obj_t wr_filtered;
    // the stored code at the read position.
    snake_pkg::obj_t rd_code;
    // high when the read position is on the outer ring.
    logic            rd_on_ring;

    // only head, body and apple can occupy a tile.
    // anything else written by the game side is kept as an empty tile.
    always_comb begin
        case (wr_code)
            snake_pkg::OBJ_HEAD,
            snake_pkg::OBJ_BODY,
            snake_pkg::OBJ_APPLE: wr_filtered = wr_code;
            default:              wr_filtered = snake_pkg::OBJ_EMPTY;
        endcase
    end

    // the board starts out empty after reset.
    // a write to a row outside the grid is dropped.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < snake_pkg::GRID_W; i++) begin
                for (int j = 0; j < snake_pkg::GRID_H; j++) begin
                    tiles[i][j] <= snake_pkg::OBJ_EMPTY;
                end
            end
        end else if (wr_en && (wr_y <= snake_pkg::Y_MAX)) begin
            tiles[wr_x][wr_y] <= wr_filtered;
        end
    end

    // the outer ring is always border, whatever was written there.
    // a row index past the last row is treated the same way.
    assign rd_on_ring = (rd_x == '0) || (rd_x == snake_pkg::X_MAX) ||
                        (rd_y == '0) || (rd_y >= snake_pkg::Y_MAX);

    // the stored code is only looked up for rows inside the grid.
    assign rd_code = (rd_y <= snake_pkg::Y_MAX) ? tiles[rd_x][rd_y] : snake_pkg::OBJ_EMPTY;

    // decode the tile into one-hot flags for the scanner.
    // on the ring only border is raised.
    always_comb begin
        border = rd_on_ring;
        head   = 1'b0;
        body   = 1'b0;
        apple  = 1'b0;
        if (!rd_on_ring) begin
            case (rd_code)
                snake_pkg::OBJ_HEAD:  head  = 1'b1;
                snake_pkg::OBJ_BODY:  body  = 1'b1;
                snake_pkg::OBJ_APPLE: apple = 1'b1;
                default: begin
                    // empty tile, all flags stay low.
                end
            endcase
        end
    end

endmodule

//--- src/snake_pkg.sv
package snake_pkg;

    // the playfield is a grid of 16 columns by 12 rows of tiles.
    localparam int GRID_W = 16;
    localparam int GRID_H = 12;

    // number of tiles visited in one full raster sweep.
    localparam int NUM_TILES = GRID_W * GRID_H;

    // a tile column or row index.
    typedef logic [3:0] coord_t;

    // an object code, as stored in the board and in the drawn frame.
    typedef logic [2:0] obj_t;

    // number of changed tiles in one sweep, at most 192.
    typedef logic [7:0] tile_count_t;

    // last column and last row of the grid, where the outer ring lies.
    localparam coord_t X_MAX = coord_t'(GRID_W - 1);
    localparam coord_t Y_MAX = coord_t'(GRID_H - 1);

    // object codes.
    // the numbering follows the redraw encoding of the display side.
    localparam obj_t OBJ_EMPTY  = 3'd0;
    localparam obj_t OBJ_HEAD   = 3'd1;
    localparam obj_t OBJ_BODY   = 3'd2;
    localparam obj_t OBJ_APPLE  = 3'd3;
    // border is never stored in the board map.
    // it is derived from the tile position alone.
    localparam obj_t OBJ_BORDER = 3'd4;

endpackage
